// ==== include/core_consts.svh ====
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// address of the first fetch after reset
`define RESET_PC    32'h0000_0000
`define NUM_REGS    32

// base opcodes
`define OP_LUI      7'b0110111
`define OP_IMM      7'b0010011
`define OP_REG      7'b0110011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_BRANCH   7'b1100011
`define OP_JAL      7'b1101111
`define OP_SYSTEM   7'b1110011

// funct3 values
`define F3_ADD      3'b000
`define F3_SLT      3'b010
`define F3_XOR      3'b100
`define F3_OR       3'b110
`define F3_AND      3'b111
`define F3_LW       3'b010
`define F3_SW       3'b010
`define F3_BEQ      3'b000
`define F3_BNE      3'b001

// funct7 and the one system word we accept
`define F7_BASE     7'b0000000
`define F7_SUB      7'b0100000
`define INST_EBREAK 32'h0010_0073

`endif

// ==== logic/core_pkg.sv ====
`default_nettype none

package core_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [1:0] {
		MEM_NONE,
		MEM_LOAD,
		MEM_STORE
	} mem_op_e;

	typedef enum logic [1:0] {
		BR_NONE,
		BR_BEQ,
		BR_BNE,
		BR_JAL
	} br_op_e;

	// decoder to execute
	typedef struct packed {
		word_t     pc;
		word_t     rs1;
		// immediate or rs2, already selected
		word_t     op_b;
		word_t     rs2;
		alu_op_e   alu_op;
		mem_op_e   mem_op;
		br_op_e    br_op;
		// branch / jump offset
		word_t     imm;
		reg_addr_t rd;
		logic      rd_we;
		logic      ebreak;
	} decoded_t;

	// execute to load/store
	typedef struct packed {
		word_t     pc;
		// alu value, pc+4 for jal, or the memory address
		word_t     result;
		word_t     store_data;
		mem_op_e   mem_op;
		reg_addr_t rd;
		logic      rd_we;
		logic      ebreak;
	} exe_result_t;

	typedef struct packed {
		logic  taken;
		word_t target;
	} redirect_t;

	// load/store to write-back
	typedef struct packed {
		word_t     pc;
		reg_addr_t rd;
		logic      rd_we;
		word_t     data;
		logic      ebreak;
	} wb_t;

	typedef struct packed {
		logic  valid;
		logic  we;
		word_t addr;
		word_t wdata;
	} dmem_req_t;

	typedef struct packed {
		logic      valid;
		word_t     pc;
		reg_addr_t rd;
		logic      we;
		word_t     data;
	} commit_t;

endpackage

`default_nettype wire

// ==== logic/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module fetch_unit import core_pkg::*; (
	input  logic      clk,
	input  logic      rst_i,
	input  logic      done_i,
	input  redirect_t redirect_i,
	input  logic      halt_i,
	input  logic      illegal_i,
	input  word_t     imem_data_i,
	output word_t     imem_addr_o,
	output word_t     inst_o,
	output word_t     pc_o,
	output logic      fetch_valid_o,
	output logic      invalid_o
);

	word_t pc_q;
	word_t next_pc;
	word_t inst_q;
	logic  pending_q;
	logic  issue_q;
	logic  stop_q;
	logic  invalid_q;
	wire   fetch_now;

	assign next_pc = redirect_i.taken ? redirect_i.target : pc_q + 32'd4;
	// on done the memory already sees the next pc, so the word lands with the pc update
	assign imem_addr_o = done_i ? next_pc : pc_q;
	assign fetch_now = (pending_q | done_i) & ~stop_q & ~halt_i;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			pc_q      <= `RESET_PC;
			pending_q <= 1'b1;
			issue_q   <= 1'b0;
			stop_q    <= 1'b0;
			invalid_q <= 1'b0;
		end else begin
			issue_q <= fetch_now;
			if (fetch_now)
				pending_q <= 1'b0;
			if (done_i)
				pc_q <= next_pc;
			// stop for good on halt or a bad opcode
			if (halt_i | (issue_q & illegal_i))
				stop_q <= 1'b1;
			if (issue_q & illegal_i)
				invalid_q <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_now)
			inst_q <= imem_data_i;
	end

	assign inst_o = inst_q;
	assign pc_o = pc_q;
	// an illegal word never leaves the fetch stage
	assign fetch_valid_o = issue_q & ~illegal_i;
	assign invalid_o = invalid_q;

	a_single_fetch: assert property (@(posedge clk) disable iff (rst_i)
		fetch_valid_o |=> !fetch_valid_o);

endmodule

`default_nettype wire

// ==== logic/decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module decoder import core_pkg::*; (
	input  word_t     inst_i,
	input  word_t     pc_i,
	input  word_t     rs1_data_i,
	input  word_t     rs2_data_i,
	output reg_addr_t rs1_addr_o,
	output reg_addr_t rs2_addr_o,
	output decoded_t  dec_o,
	output logic      illegal_o
);

	logic [6:0] opcode;
	logic [2:0] f3;
	logic [6:0] f7;
	reg_addr_t  rd;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_j;
	word_t      imm_u;
	logic       rd_we;

	assign opcode = inst_i[6:0];
	assign rd     = inst_i[11:7];
	assign f3     = inst_i[14:12];
	assign f7     = inst_i[31:25];

	assign rs1_addr_o = inst_i[19:15];
	assign rs2_addr_o = inst_i[24:20];

	assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
	assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
	assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
	assign imm_u = {inst_i[31:12], 12'b0};

	always_comb begin
		dec_o        = '0;
		dec_o.pc     = pc_i;
		dec_o.rs1    = rs1_data_i;
		dec_o.rs2    = rs2_data_i;
		dec_o.op_b   = imm_i;
		dec_o.rd     = rd;
		dec_o.alu_op = ALU_ADD;
		dec_o.mem_op = MEM_NONE;
		dec_o.br_op  = BR_NONE;
		rd_we        = 1'b0;
		illegal_o    = 1'b0;

		case (opcode)
			`OP_LUI: begin
				dec_o.op_b   = imm_u;
				dec_o.alu_op = ALU_PASS_B;
				rd_we        = 1'b1;
			end
			`OP_IMM: begin
				rd_we = 1'b1;
				case (f3)
					`F3_ADD: dec_o.alu_op = ALU_ADD;
					`F3_SLT: dec_o.alu_op = ALU_SLT;
					`F3_XOR: dec_o.alu_op = ALU_XOR;
					`F3_OR:  dec_o.alu_op = ALU_OR;
					`F3_AND: dec_o.alu_op = ALU_AND;
					default: illegal_o = 1'b1;
				endcase
			end
			`OP_REG: begin
				dec_o.op_b = rs2_data_i;
				rd_we      = 1'b1;
				if (f7 == `F7_SUB && f3 == `F3_ADD)
					dec_o.alu_op = ALU_SUB;
				else if (f7 != `F7_BASE)
					illegal_o = 1'b1;
				else begin
					case (f3)
						`F3_ADD: dec_o.alu_op = ALU_ADD;
						`F3_SLT: dec_o.alu_op = ALU_SLT;
						`F3_XOR: dec_o.alu_op = ALU_XOR;
						`F3_OR:  dec_o.alu_op = ALU_OR;
						`F3_AND: dec_o.alu_op = ALU_AND;
						default: illegal_o = 1'b1;
					endcase
				end
			end
			`OP_LOAD: begin
				dec_o.mem_op = MEM_LOAD;
				rd_we        = 1'b1;
				illegal_o    = (f3 != `F3_LW);
			end
			`OP_STORE: begin
				dec_o.op_b   = imm_s;
				dec_o.mem_op = MEM_STORE;
				illegal_o    = (f3 != `F3_SW);
			end
			`OP_BRANCH: begin
				dec_o.op_b = rs2_data_i;
				dec_o.imm  = imm_b;
				case (f3)
					`F3_BEQ: dec_o.br_op = BR_BEQ;
					`F3_BNE: dec_o.br_op = BR_BNE;
					default: illegal_o = 1'b1;
				endcase
			end
			`OP_JAL: begin
				dec_o.imm   = imm_j;
				dec_o.br_op = BR_JAL;
				rd_we       = 1'b1;
			end
			`OP_SYSTEM: begin
				dec_o.ebreak = (inst_i == `INST_EBREAK);
				illegal_o    = (inst_i != `INST_EBREAK);
			end
			default: illegal_o = 1'b1;
		endcase

		// writes to x0 are dropped here
		dec_o.rd_we = rd_we & (rd != 5'd0);
	end

endmodule

`default_nettype wire

// ==== logic/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module register_file import core_pkg::*; (
	input  logic      clk,
	input  logic      rst_i,
	input  reg_addr_t raddr1_i,
	input  reg_addr_t raddr2_i,
	input  logic      we_i,
	input  reg_addr_t waddr_i,
	input  word_t     wdata_i,
	output word_t     rdata1_o,
	output word_t     rdata2_o
);

	word_t regs [`NUM_REGS];

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < `NUM_REGS; i++)
				regs[i] <= '0;
		end else if (we_i) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// x0 reads as zero
	assign rdata1_o = (raddr1_i == 5'd0) ? '0 : regs[raddr1_i];
	assign rdata2_o = (raddr2_i == 5'd0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

// ==== logic/execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_unit import core_pkg::*; (
	input  logic        clk,
	input  logic        rst_i,
	input  logic        valid_i,
	input  decoded_t    dec_i,
	output logic        valid_o,
	output exe_result_t res_o,
	output redirect_t   redirect_o
);

	word_t       alu_res;
	logic        taken;
	logic        valid_q;
	exe_result_t res_q;
	redirect_t   redirect_q;

	always_comb begin
		case (dec_i.alu_op)
			ALU_ADD:    alu_res = dec_i.rs1 + dec_i.op_b;
			ALU_SUB:    alu_res = dec_i.rs1 - dec_i.op_b;
			ALU_AND:    alu_res = dec_i.rs1 & dec_i.op_b;
			ALU_OR:     alu_res = dec_i.rs1 | dec_i.op_b;
			ALU_XOR:    alu_res = dec_i.rs1 ^ dec_i.op_b;
			ALU_SLT:    alu_res = {31'b0, $signed(dec_i.rs1) < $signed(dec_i.op_b)};
			ALU_PASS_B: alu_res = dec_i.op_b;
			default:    alu_res = '0;
		endcase
	end

	always_comb begin
		case (dec_i.br_op)
			BR_BEQ:  taken = (dec_i.rs1 == dec_i.rs2);
			BR_BNE:  taken = (dec_i.rs1 != dec_i.rs2);
			BR_JAL:  taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_q    <= 1'b0;
			redirect_q <= '0;
		end else begin
			valid_q <= valid_i;
			// redirect holds until the next instruction passes
			if (valid_i) begin
				redirect_q.taken  <= taken;
				redirect_q.target <= dec_i.pc + dec_i.imm;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (valid_i) begin
			res_q.pc         <= dec_i.pc;
			res_q.result     <= (dec_i.br_op == BR_JAL) ? dec_i.pc + 32'd4 : alu_res;
			res_q.store_data <= dec_i.rs2;
			res_q.mem_op     <= dec_i.mem_op;
			res_q.rd         <= dec_i.rd;
			res_q.rd_we      <= dec_i.rd_we;
			res_q.ebreak     <= dec_i.ebreak;
		end
	end

	assign valid_o = valid_q;
	assign res_o = res_q;
	assign redirect_o = redirect_q;

endmodule

`default_nettype wire

// ==== logic/load_store_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_store_unit import core_pkg::*; (
	input  logic        clk,
	input  logic        rst_i,
	input  logic        valid_i,
	input  exe_result_t res_i,
	input  word_t       dmem_rdata_i,
	output dmem_req_t   dmem_req_o,
	output logic        valid_o,
	output wb_t         wb_o
);

	logic valid_q;
	wb_t  wb_q;

	// request only while the bundle is valid
	assign dmem_req_o.valid = valid_i & (res_i.mem_op != MEM_NONE);
	assign dmem_req_o.we    = valid_i & (res_i.mem_op == MEM_STORE);
	assign dmem_req_o.addr  = res_i.result;
	assign dmem_req_o.wdata = res_i.store_data;

	always_ff @(posedge clk) begin
		if (rst_i)
			valid_q <= 1'b0;
		else
			valid_q <= valid_i;
	end

	always_ff @(posedge clk) begin
		if (valid_i) begin
			wb_q.pc     <= res_i.pc;
			wb_q.rd     <= res_i.rd;
			wb_q.rd_we  <= res_i.rd_we;
			wb_q.data   <= (res_i.mem_op == MEM_LOAD) ? dmem_rdata_i : res_i.result;
			wb_q.ebreak <= res_i.ebreak;
		end
	end

	assign valid_o = valid_q;
	assign wb_o = wb_q;

	// only whole-word accesses are supported
	a_word_aligned: assert property (@(posedge clk) disable iff (rst_i)
		dmem_req_o.valid |-> dmem_req_o.addr[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== logic/writeback_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeback_unit import core_pkg::*; (
	input  logic      clk,
	input  logic      rst_i,
	input  logic      valid_i,
	input  wb_t       wb_i,
	output logic      rf_we_o,
	output reg_addr_t rf_waddr_o,
	output word_t     rf_wdata_o,
	output commit_t   commit_o,
	output logic      done_o,
	output logic      halt_o
);

	logic halt_q;

	// the write lands at the edge closing this cycle
	assign rf_we_o    = valid_i & wb_i.rd_we;
	assign rf_waddr_o = wb_i.rd;
	assign rf_wdata_o = wb_i.data;

	assign commit_o.valid = valid_i;
	assign commit_o.pc    = wb_i.pc;
	assign commit_o.rd    = wb_i.rd;
	assign commit_o.we    = wb_i.rd_we;
	assign commit_o.data  = wb_i.data;

	// ebreak retires but starts no further fetch
	assign done_o = valid_i & ~wb_i.ebreak & ~halt_q;

	always_ff @(posedge clk) begin
		if (rst_i)
			halt_q <= 1'b0;
		else if (valid_i & wb_i.ebreak)
			halt_q <= 1'b1;
	end

	assign halt_o = halt_q;

	// nothing may still be in flight behind the ebreak
	a_quiet_after_halt: assert property (@(posedge clk) disable iff (rst_i)
		halt_q |-> !valid_i);

endmodule

`default_nettype wire

// ==== logic/core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_top import core_pkg::*; (
	input  logic      clk,
	input  logic      rst_i,
	output word_t     imem_addr_o,
	input  word_t     imem_data_i,
	output dmem_req_t dmem_req_o,
	input  word_t     dmem_rdata_i,
	output commit_t   commit_o,
	output logic      halt_o,
	output logic      invalid_o
);

	// fetch / decode
	logic        fetch_valid;
	word_t       inst;
	word_t       pc;
	logic        illegal;
	decoded_t    dec;
	reg_addr_t   rs1_addr;
	reg_addr_t   rs2_addr;
	word_t       rs1_data;
	word_t       rs2_data;

	// execute and later
	logic        exe_valid;
	exe_result_t exe_res;
	redirect_t   redirect;
	logic        lsu_valid;
	wb_t         wb;
	logic        rf_we;
	reg_addr_t   rf_waddr;
	word_t       rf_wdata;
	logic        done;
	logic        halt;

	assign halt_o = halt;

	fetch_unit u_fetch (
		.clk           (clk),
		.rst_i         (rst_i),
		.done_i        (done),
		.redirect_i    (redirect),
		.halt_i        (halt),
		.illegal_i     (illegal),
		.imem_data_i   (imem_data_i),
		.imem_addr_o   (imem_addr_o),
		.inst_o        (inst),
		.pc_o          (pc),
		.fetch_valid_o (fetch_valid),
		.invalid_o     (invalid_o)
	);

	decoder u_decoder (
		.inst_i     (inst),
		.pc_i       (pc),
		.rs1_data_i (rs1_data),
		.rs2_data_i (rs2_data),
		.rs1_addr_o (rs1_addr),
		.rs2_addr_o (rs2_addr),
		.dec_o      (dec),
		.illegal_o  (illegal)
	);

	register_file u_regfile (
		.clk      (clk),
		.rst_i    (rst_i),
		.raddr1_i (rs1_addr),
		.raddr2_i (rs2_addr),
		.we_i     (rf_we),
		.waddr_i  (rf_waddr),
		.wdata_i  (rf_wdata),
		.rdata1_o (rs1_data),
		.rdata2_o (rs2_data)
	);

	execute_unit u_execute (
		.clk        (clk),
		.rst_i      (rst_i),
		.valid_i    (fetch_valid),
		.dec_i      (dec),
		.valid_o    (exe_valid),
		.res_o      (exe_res),
		.redirect_o (redirect)
	);

	load_store_unit u_lsu (
		.clk          (clk),
		.rst_i        (rst_i),
		.valid_i      (exe_valid),
		.res_i        (exe_res),
		.dmem_rdata_i (dmem_rdata_i),
		.dmem_req_o   (dmem_req_o),
		.valid_o      (lsu_valid),
		.wb_o         (wb)
	);

	writeback_unit u_writeback (
		.clk        (clk),
		.rst_i      (rst_i),
		.valid_i    (lsu_valid),
		.wb_i       (wb),
		.rf_we_o    (rf_we),
		.rf_waddr_o (rf_waddr),
		.rf_wdata_o (rf_wdata),
		.commit_o   (commit_o),
		.done_o     (done),
		.halt_o     (halt)
	);

endmodule

`default_nettype wire

// ==== bench/core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module core_tb import core_pkg::*; ();

	localparam int reset_cycles = 8;
	localparam int mem_words = 256;
	// addi x31, x31, 1 on a skipped path, so a wrong fetch shows up as a commit
	localparam word_t skip_word = {12'd1, 5'd31, `F3_ADD, 5'd31, `OP_IMM};

	logic      clk;
	logic      rst_i;
	word_t     imem_addr;
	dmem_req_t dmem_req;
	commit_t   commit;
	logic      halt;
	logic      invalid;

	word_t imem [mem_words];
	word_t dmem [mem_words];

	// expected commits, filled in as the program is assembled
	word_t     exp_pc [64];
	logic      exp_we [64];
	reg_addr_t exp_rd [64];
	word_t     exp_data [64];
	logic      exp_brk [64];
	int        exp_test [64];
	int        n_exp;
	word_t     st_addr [8];
	word_t     st_data [8];
	int        n_st;

	// reference state of the program builder
	word_t bpc;
	word_t mregs [32];
	word_t mmem [mem_words];
	int    cur_test;
	logic  expect_invalid;
	int    budget;

	int    cidx;
	int    sidx;
	int    since;
	int    wd;
	int    ct;
	int    end_test;
	string test_names [6] = '{"alu", "x0", "memory", "control", "spacing_halt", "illegal"};
	int    checks [6];
	int    fails [6];
	int    errors;
	int    passed;
	int    failed;

	core_top DUT (
		.clk          (clk),
		.rst_i        (rst_i),
		.imem_addr_o  (imem_addr),
		.imem_data_i  (imem[imem_addr[9:2]]),
		.dmem_req_o   (dmem_req),
		.dmem_rdata_i (dmem[dmem_req.addr[9:2]]),
		.commit_o     (commit),
		.halt_o       (halt),
		.invalid_o    (invalid)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	assign ct = exp_test[cidx[5:0]];
	assign end_test = expect_invalid ? 5 : 4;

	// stores land at the clock edge
	always @(posedge clk) begin
		if (!rst_i && dmem_req.valid && dmem_req.we)
			dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
	end

	always @(posedge clk) begin
		if (rst_i) begin
			cidx  <= 0;
			sidx  <= 0;
			since <= 0;
			wd    <= 0;
		end else begin
			wd    <= wd + 1;
			since <= commit.valid ? 1 : since + 1;
			if (commit.valid) begin
				cidx <= cidx + 1;
				if (cidx < n_exp)
					checks[ct] <= checks[ct] + 1;
			end
			if (dmem_req.valid && dmem_req.we)
				sidx <= sidx + 1;
			if (wd > budget) begin
				$display("watchdog: no halt or invalid flag within %0d cycles", budget);
				$display("Something failed");
				$finish;
			end
		end
	end

	task automatic report_mismatch(input int t, input string what, input word_t e, input word_t a);
		errors++;
		fails[t]++;
		$display("error %s %s: expected %h, actual %h", test_names[t], what, e, a);
	endtask

	task automatic report_failure(input int t, input string msg);
		errors++;
		fails[t]++;
		$display("%s: %s", test_names[t], msg);
	endtask

	a_commit_known: assert property (@(posedge clk) disable iff (rst_i)
		commit.valid |-> cidx < n_exp)
		else report_failure($sampled(end_test), "commit after the last expected one");
	a_commit_pc: assert property (@(posedge clk) disable iff (rst_i)
		commit.valid |-> commit.pc == exp_pc[cidx])
		else report_mismatch($sampled(ct), "pc", exp_pc[$sampled(cidx)], $sampled(commit.pc));
	a_commit_we: assert property (@(posedge clk) disable iff (rst_i)
		commit.valid |-> commit.we == exp_we[cidx])
		else report_mismatch($sampled(ct), "write enable", word_t'(exp_we[$sampled(cidx)]),
			word_t'($sampled(commit.we)));
	a_commit_rd: assert property (@(posedge clk) disable iff (rst_i)
		commit.valid && exp_we[cidx] |-> commit.rd == exp_rd[cidx])
		else report_mismatch($sampled(ct), "rd", word_t'(exp_rd[$sampled(cidx)]),
			word_t'($sampled(commit.rd)));
	a_commit_data: assert property (@(posedge clk) disable iff (rst_i)
		commit.valid && exp_we[cidx] |-> commit.data == exp_data[cidx])
		else report_mismatch($sampled(ct), "data", exp_data[$sampled(cidx)], $sampled(commit.data));
	a_store_addr: assert property (@(posedge clk) disable iff (rst_i)
		dmem_req.valid && dmem_req.we |-> dmem_req.addr == st_addr[sidx])
		else report_mismatch(2, "store address", st_addr[$sampled(sidx)], $sampled(dmem_req.addr));
	a_store_data: assert property (@(posedge clk) disable iff (rst_i)
		dmem_req.valid && dmem_req.we |-> dmem_req.wdata == st_data[sidx])
		else report_mismatch(2, "store data", st_data[$sampled(sidx)], $sampled(dmem_req.wdata));
	a_spacing: assert property (@(posedge clk) disable iff (rst_i)
		commit.valid |-> since == 3)
		else report_mismatch(4, "commit spacing", 32'd3, word_t'($sampled(since)));
	a_halt_after_ebreak: assert property (@(posedge clk) disable iff (rst_i)
		commit.valid && exp_brk[cidx] |=> halt)
		else report_failure(4, "halt_o did not rise after the ebreak commit");
	a_halt_cause: assert property (@(posedge clk) disable iff (rst_i)
		$rose(halt) |-> $past(commit.valid))
		else report_failure(4, "halt_o rose without a commit just before it");
	a_halt_quiet: assert property (@(posedge clk) disable iff (rst_i)
		halt |-> !commit.valid)
		else report_failure(4, "a commit came after halt_o");
	a_halt_count: assert property (@(posedge clk) disable iff (rst_i)
		halt |-> cidx == n_exp)
		else report_mismatch(4, "commit count", word_t'(n_exp), word_t'($sampled(cidx)));
	a_halt_wanted: assert property (@(posedge clk) disable iff (rst_i)
		halt |-> !expect_invalid)
		else report_failure(5, "halt_o rose in the illegal-opcode program");
	a_invalid_wanted: assert property (@(posedge clk) disable iff (rst_i)
		invalid |-> expect_invalid)
		else report_failure(4, "invalid_o rose in the main program");
	a_invalid_count: assert property (@(posedge clk) disable iff (rst_i)
		invalid |-> cidx == n_exp)
		else report_mismatch(5, "commit count", word_t'(n_exp), word_t'($sampled(cidx)));
	a_invalid_quiet: assert property (@(posedge clk) disable iff (rst_i)
		invalid |-> !commit.valid && $stable(imem_addr))
		else report_failure(5, "commit or fetch address change after invalid_o");

	// RV32I result rules for the ALU ops in use
	function automatic word_t alu_ref(input logic sub, input logic [2:0] f3, input word_t a,
			input word_t b);
		case (f3)
			`F3_ADD: return sub ? a - b : a + b;
			`F3_SLT: return word_t'($signed(a) < $signed(b));
			`F3_XOR: return a ^ b;
			`F3_OR:  return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic [11:0] rand_imm();
		return 12'($urandom);
	endfunction

	task automatic emit(input word_t w, input logic we, input reg_addr_t rd, input word_t data,
			input logic brk);
		exp_pc[n_exp]   = bpc;
		exp_we[n_exp]   = we && (rd != 5'd0);
		exp_rd[n_exp]   = rd;
		exp_data[n_exp] = data;
		exp_brk[n_exp]  = brk;
		exp_test[n_exp] = cur_test;
		n_exp++;
		if (we && rd != 5'd0)
			mregs[rd] = data;
		imem[bpc[9:2]] = w;
		bpc = bpc + 32'd4;
	endtask

	task automatic skip_to(input word_t target);
		while (bpc != target) begin
			imem[bpc[9:2]] = skip_word;
			bpc = bpc + 32'd4;
		end
	endtask

	task automatic lui(input reg_addr_t rd, input logic [19:0] u);
		emit({u, rd, `OP_LUI}, 1'b1, rd, {u, 12'b0}, 1'b0);
	endtask

	task automatic op_imm(input logic [2:0] f3, input reg_addr_t rd, input reg_addr_t rs1,
			input logic [11:0] imm);
		emit({imm, rs1, f3, rd, `OP_IMM}, 1'b1, rd,
			alu_ref(1'b0, f3, mregs[rs1], {{20{imm[11]}}, imm}), 1'b0);
	endtask

	task automatic op_reg(input logic sub, input logic [2:0] f3, input reg_addr_t rd,
			input reg_addr_t rs1, input reg_addr_t rs2);
		emit({(sub ? `F7_SUB : `F7_BASE), rs2, rs1, f3, rd, `OP_REG}, 1'b1, rd,
			alu_ref(sub, f3, mregs[rs1], mregs[rs2]), 1'b0);
	endtask

	task automatic store(input reg_addr_t rs2, input reg_addr_t rs1, input logic [11:0] off);
		word_t a;
		a = mregs[rs1] + {{20{off[11]}}, off};
		st_addr[n_st] = a;
		st_data[n_st] = mregs[rs2];
		n_st++;
		mmem[a[9:2]] = mregs[rs2];
		emit({off[11:5], rs2, rs1, `F3_SW, off[4:0], `OP_STORE}, 1'b0, 5'd0, '0, 1'b0);
	endtask

	task automatic load(input reg_addr_t rd, input reg_addr_t rs1, input logic [11:0] off);
		word_t a;
		a = mregs[rs1] + {{20{off[11]}}, off};
		emit({off, rs1, `F3_LW, rd, `OP_LOAD}, 1'b1, rd, mmem[a[9:2]], 1'b0);
	endtask

	task automatic branch(input logic [2:0] f3, input reg_addr_t rs1, input reg_addr_t rs2,
			input logic [12:0] off);
		word_t at;
		logic  taken;
		at = bpc;
		taken = (f3 == `F3_BEQ) ? (mregs[rs1] == mregs[rs2]) : (mregs[rs1] != mregs[rs2]);
		emit({off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OP_BRANCH},
			1'b0, 5'd0, '0, 1'b0);
		if (taken)
			skip_to(at + {{19{off[12]}}, off});
	endtask

	task automatic jal(input reg_addr_t rd, input logic [20:0] off);
		word_t at;
		at = bpc;
		emit({off[20], off[10:1], off[11], off[19:12], rd, `OP_JAL}, 1'b1, rd, at + 32'd4, 1'b0);
		skip_to(at + {{11{off[20]}}, off});
	endtask

	task automatic clear_program();
		for (int i = 0; i < mem_words; i++) begin
			imem[i] = '0;
			dmem[i] = word_t'(i) * 32'h9e37_79b9 ^ 32'h0bad_0000;
			mmem[i] = dmem[i];
		end
		for (int i = 0; i < 32; i++)
			mregs[i] = '0;
		n_exp = 0;
		n_st = 0;
		bpc = `RESET_PC;
	endtask

	task automatic build_main();
		clear_program();
		cur_test = 0;
		lui(1, 20'($urandom));
		op_imm(`F3_ADD, 2, 0, rand_imm());
		op_imm(`F3_ADD, 3, 0, rand_imm());
		op_imm(`F3_ADD, 1, 1, rand_imm());
		op_imm(`F3_AND, 4, 2, rand_imm());
		op_imm(`F3_OR, 5, 3, rand_imm());
		op_imm(`F3_XOR, 6, 2, rand_imm());
		op_imm(`F3_SLT, 7, 2, rand_imm());
		op_reg(1'b0, `F3_ADD, 8, 2, 3);
		op_reg(1'b1, `F3_ADD, 9, 2, 3);
		op_reg(1'b0, `F3_AND, 10, 4, 5);
		op_reg(1'b0, `F3_OR, 11, 4, 5);
		op_reg(1'b0, `F3_XOR, 12, 6, 1);
		op_reg(1'b0, `F3_SLT, 13, 2, 3);
		op_reg(1'b0, `F3_SLT, 21, 3, 2);
		cur_test = 1;
		op_imm(`F3_ADD, 0, 2, rand_imm());
		op_reg(1'b0, `F3_ADD, 14, 0, 3);
		op_reg(1'b1, `F3_ADD, 22, 3, 0);
		cur_test = 2;
		op_imm(`F3_ADD, 15, 0, 12'h100);
		store(8, 15, 12'h008);
		load(16, 15, 12'h008);
		store(1, 15, 12'hffc);
		load(17, 15, 12'hffc);
		load(23, 15, 12'h040);
		cur_test = 3;
		op_imm(`F3_ADD, 18, 0, 12'd5);
		branch(`F3_BEQ, 18, 18, 13'd12);
		branch(`F3_BNE, 18, 18, 13'd8);
		jal(19, 21'd8);
		op_imm(`F3_ADD, 20, 19, 12'd0);
		cur_test = 4;
		emit(`INST_EBREAK, 1'b0, 5'd0, '0, 1'b1);
	endtask

	task automatic build_illegal();
		clear_program();
		cur_test = 5;
		op_imm(`F3_ADD, 1, 0, rand_imm());
		op_reg(1'b0, `F3_ADD, 2, 1, 1);
		// opcode 7f is not decoded; the addi behind it must never be fetched
		imem[bpc[9:2]] = 32'hffff_ffff;
		imem[bpc[9:2] + 8'd1] = {12'd1, 5'd0, `F3_ADD, 5'd3, `OP_IMM};
	endtask

	task automatic release_reset();
		budget = 3 * n_exp + reset_cycles + 50;
		repeat (reset_cycles) @(negedge clk);
		rst_i = 1'b0;
	endtask

	task automatic report_tests(input int first, input int last);
		for (int t = first; t <= last; t++) begin
			if (fails[t] == 0 && checks[t] > 0)
				passed++;
			else
				failed++;
			$display("test %s: %0d commits checked, %0d errors, %s", test_names[t], checks[t],
				fails[t], (fails[t] == 0 && checks[t] > 0) ? "passed" : "failed");
		end
	endtask

	initial begin
		void'($urandom(32'h1c3c_ee27));
		rst_i = 1'b1;
		expect_invalid = 1'b0;
		errors = 0;
		passed = 0;
		failed = 0;
		build_main();
		release_reset();
		wait (halt || invalid);
		repeat (8) @(negedge clk);
		report_tests(0, 4);

		// second run, behind a fresh reset
		rst_i = 1'b1;
		expect_invalid = 1'b1;
		build_illegal();
		release_reset();
		wait (halt || invalid);
		repeat (8) @(negedge clk);
		report_tests(5, 5);

		$display("%0d tests passed, %0d failed, %0d errors", passed, failed, errors);
		if (errors == 0 && failed == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+include
logic/core_pkg.sv
logic/fetch_unit.sv
logic/decoder.sv
logic/register_file.sv
logic/execute_unit.sv
logic/load_store_unit.sv
logic/writeback_unit.sv
logic/core_top.sv
bench/core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= core_tb
RTL_TOP   ?= core_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# the run fails unless the pass message shows up on a line of its own
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
